// ==== project.f ====
+incdir+source
source/smpc_host_pkg.sv
source/smpc_ctrl_pkg.sv
source/smpc_bus_regs.sv
source/smpc_reset_seq.sv
source/smpc_rtc.sv
source/smpc_oreg_report.sv
source/smpc_top.sv
verif/smpc_sva.sv
verif/tb_smpc.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f project.f --top-module tb_smpc -o sim_smpc &&
./obj_dir/sim_smpc | tee /dev/stderr | grep -qF 'All tests passed!' &&
echo "Simulation passed" || { echo "Simulation failed"; exit 1; }

// ==== verif/tb_smpc.sv ====
`timescale 1ns/100ps
`include "smpc_defs.svh"

module tb_smpc;
	import smpc_host_pkg::*;
	import smpc_ctrl_pkg::*;

	localparam int SRES_LIMIT = `SMPC_WAIT_SRES * 2;
	localparam longint WATCHDOG_CYCLES = (`SMPC_WAIT_PWR + `SMPC_WAIT_CD + `SMPC_WAIT_SYSRES
		+ `SMPC_WAIT_INTBACK + `SMPC_WAIT_NMI + `SMPC_WAIT_SRES) * 2 + 20000;
	localparam byte_t POWER_CMDS [9] = '{CMD_MSHON, CMD_SSHON, CMD_SNDON, CMD_CDOFF,
		CMD_SSHOFF, CMD_SNDOFF, CMD_CDON, 8'h55, CMD_SSHON};

	logic       CLK = 1'b0;
	logic       RST_N = 1'b0;
	logic       CE = 1'b0;
	logic       CS_N = 1'b1;
	logic       RW_N = 1'b1;
	logic       SRES_N = 1'b1;
	bus_addr_t  A = '0;
	byte_t      DI = '0;
	logic [3:0] AC = 4'h5;
	byte_t      DO;
	logic       MSHRES_N, MSHNMI_N, SSHRES_N, SSHNMI_N, SYSRES_N, SNDRES_N, CDRES_N, MIRQ_N;
	logic [31:0] lfsr = 32'h01fc59d3;
	logic [7:0] lines;
	logic [7:0] exp_lines = 8'h6D; // Line values after reset
	logic [7:0] low_seen = 8'h00;
	logic       clear_seen = 1'b0;
	logic       exp_resd = 1'b1;
	int         ce_count = 0;
	int         mirq_cnt = 0;
	int         mirq_ce = 0;

	assign lines = {1'b0, MSHRES_N, MSHNMI_N, SSHRES_N, SSHNMI_N, SYSRES_N, SNDRES_N, CDRES_N};

	smpc_top #(.SEC_DIV(4)) u_dut (
		.CLK, .RST_N, .CE, .A, .DI, .DO, .CS_N, .RW_N, .SRES_N, .AC, .MSHRES_N, .MSHNMI_N,
		.SSHRES_N, .SSHNMI_N, .SYSRES_N, .SNDRES_N, .CDRES_N, .MIRQ_N
	);

	bind smpc_top smpc_sva u_sva (
		.CLK, .RST_N, .cmd_valid, .cmd_ready, .report_valid, .report_ready, .MSHRES_N,
		.MSHNMI_N, .SSHRES_N, .SSHNMI_N, .SYSRES_N, .SNDRES_N, .CDRES_N, .MIRQ_N
	);

	always #2 CLK = ~CLK;

	// Taps 32, 22, 2, 1
	function automatic logic lfsr_bit();
		lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
		return lfsr[0];
	endfunction

	always @(posedge CLK) begin
		logic b1;
		logic b2;
		#0.5;
		b1 = lfsr_bit();
		b2 = lfsr_bit();
		CE = b1 | b2;
	end

	always @(posedge CLK) begin
		if (RST_N && CE) ce_count <= ce_count + 1;
		if (!MIRQ_N) begin
			mirq_cnt <= mirq_cnt + 1;
			mirq_ce <= ce_count + 1; // CE count including this edge
		end
		if (clear_seen) low_seen <= 8'h00;
		else low_seen <= low_seen | {1'b0, ~lines[6:0]};
	end

	task automatic stop_with_failure(input string msg);
		$display("%s", msg);
		$display("Test failures found");
		$fatal(1);
	endtask

	always @(posedge CLK) begin
		if (u_dut.u_sva.err_cnt != 0) stop_with_failure("A bound assertion on the DUT failed");
	end

	task automatic check_eq(input string name, input logic [7:0] got, input logic [7:0] exp);
		assert (got === exp)
		else stop_with_failure($sformatf("Mismatch at %0t: %s = %h, expected %h",
			$time, name, got, exp));
	endtask

	function automatic byte_t to_bcd(input int v);
		return byte_t'(((v / 10) << 4) | (v % 10));
	endfunction

	// Packed day, hour, min, sec after a number of ticks
	function automatic logic [31:0] bcd_time(input int ticks);
		return {to_bcd((ticks / 86400) % 100), to_bcd((ticks / 3600) % 24),
			to_bcd((ticks / 60) % 60), to_bcd(ticks % 60)};
	endfunction

	function automatic logic [6:0] oreg_addr(input int n);
		return 7'(8'h21 + 2 * n);
	endfunction

	task automatic clear_low_seen();
		clear_seen = 1'b1;
		@(posedge CLK);
		#0.5;
		clear_seen = 1'b0;
	endtask

	task automatic bus_write(input logic [6:0] addr, input byte_t data);
		A = addr[6:1];
		DI = data;
		RW_N = 1'b0;
		CS_N = 1'b0;
		repeat (4) @(posedge CLK);
		#0.5;
		CS_N = 1'b1;
		RW_N = 1'b1;
		@(posedge CLK);
		#0.5;
	endtask

	task automatic bus_read(input logic [6:0] addr, output byte_t data);
		A = addr[6:1];
		CS_N = 1'b0;
		repeat (4) @(posedge CLK);
		#0.5;
		data = DO;
		CS_N = 1'b1;
		@(posedge CLK);
		#0.5;
	endtask

	task automatic run_cmd(input byte_t code, input logic echo);
		byte_t sf;
		byte_t rd;
		int polls;
		clear_low_seen();
		bus_write(`SMPC_ADDR_COMREG, code);
		sf = 8'h01;
		polls = 0;
		while (sf[0]) begin
			bus_read(`SMPC_ADDR_SF, sf);
			polls++;
			assert (polls < 1000) else stop_with_failure("Command never finished, SF stayed set");
		end
		case (code)
			CMD_MSHON: exp_lines[6:5] = 2'b11;
			CMD_SSHON: exp_lines[4:3] = 2'b11;
			CMD_SSHOFF: exp_lines[4:3] = 2'b01;
			CMD_SNDON: exp_lines[1] = 1'b1;
			CMD_SNDOFF: exp_lines[1] = 1'b0;
			CMD_CDON: exp_lines[0] = 1'b1;
			CMD_CDOFF: exp_lines[0] = 1'b0;
			CMD_SYSRES: exp_lines = 8'h7F;
			CMD_RESENAB: exp_resd = 1'b0;
			CMD_RESDISA: exp_resd = 1'b1;
			default: ;
		endcase
		check_eq("reset lines", lines, exp_lines);
		if (echo) begin
			bus_read(oreg_addr(31), rd);
			check_eq("OREG31", rd, code);
		end
	endtask

	initial begin
		byte_t rd;
		byte_t rpt [12];
		logic [31:0] t_now;
		logic [31:0] t_prev;
		int base;
		int k;
		int waited;
		repeat (8) @(posedge CLK);
		#0.5;
		RST_N = 1'b1;
		check_eq("DO", DO, 8'h00);
		check_eq("MIRQ_N", {7'b0, MIRQ_N}, 8'h01);
		check_eq("reset lines", lines, exp_lines);
		bus_read(`SMPC_ADDR_SF, rd);
		check_eq("SF", rd, 8'h00);

		foreach (POWER_CMDS[i]) run_cmd(POWER_CMDS[i], 1'b1);
		run_cmd(CMD_SYSRES, 1'b1);
		check_eq("lines low during SYSRES", low_seen, 8'h7F);
		run_cmd(CMD_NMIREQ, 1'b1);
		check_eq("lines low during NMIREQ", low_seen, 8'h20);

		base = mirq_cnt;
		run_cmd(CMD_INTBACK, 1'b0); // IREG2 still zero
		check_eq("MIRQ_N pulses", 8'(mirq_cnt - base), 8'h00);
		// Hours need 3600 ticks of 4 CE cycles
		while (ce_count < 15000) begin
			@(posedge CLK);
			#0.5;
		end
		bus_write(7'h01, 8'h01);
		bus_write(7'h03, 8'hA5);
		bus_write(7'h05, 8'hF0);
		base = mirq_cnt;
		run_cmd(CMD_INTBACK, 1'b1);
		check_eq("MIRQ_N pulses", 8'(mirq_cnt - base), 8'h01);
		bus_read(`SMPC_ADDR_SR, rd);
		check_eq("SR", rd, 8'h4A);
		for (int i = 0; i < 12; i++) bus_read(oreg_addr(i), rpt[i]);
		check_eq("report byte 0", rpt[0], {1'b0, exp_resd, 6'b000000});
		check_eq("report byte 1", rpt[1], `SMPC_RPT_B1);
		check_eq("report byte 2", rpt[2], `SMPC_RPT_B2);
		check_eq("report byte 3", rpt[3], `SMPC_RPT_B3);
		check_eq("report byte 8", rpt[8], 8'h00);
		check_eq("report byte 9", rpt[9], {4'h0, AC});
		check_eq("report byte 10", rpt[10], {4'b0011, ~exp_lines[5], 1'b1, ~exp_lines[2:1]});
		check_eq("report byte 11", rpt[11], {1'b0, ~exp_lines[0], 6'b000000});
		k = (mirq_ce - 26) / 4; // Ticks seen when byte 7 was stored
		t_now = bcd_time(k);
		t_prev = bcd_time(k - 1);
		for (int i = 0; i < 4; i++) begin
			assert (rpt[4 + i] === t_now[8 * (3 - i) +: 8]
				|| rpt[4 + i] === t_prev[8 * (3 - i) +: 8])
			else stop_with_failure($sformatf(
				"Mismatch at %0t: report byte %0d = %h, expected %h or %h",
				$time, 4 + i, rpt[4 + i], t_now[8 * (3 - i) +: 8], t_prev[8 * (3 - i) +: 8]));
		end

		run_cmd(CMD_RESENAB, 1'b1);
		SRES_N = 1'b0;
		waited = 0;
		while (MSHNMI_N || SSHNMI_N) begin
			@(posedge CLK);
			#0.5;
			waited++;
			assert (waited < 64) else stop_with_failure("Reset button did not pull NMI lines low");
		end
		SRES_N = 1'b1;
		waited = 0;
		while (!MSHNMI_N || !SSHNMI_N) begin
			@(posedge CLK);
			#0.5;
			waited++;
			assert (waited < SRES_LIMIT) else stop_with_failure("NMI lines stayed low too long");
		end
		check_eq("reset lines", lines, exp_lines);
		run_cmd(CMD_RESDISA, 1'b1);
		clear_low_seen();
		SRES_N = 1'b0;
		repeat (64) @(posedge CLK);
		#0.5;
		SRES_N = 1'b1;
		check_eq("NMI lines low with resets disabled", low_seen & 8'h28, 8'h00);

		if (u_dut.u_sva.err_cnt == 0) begin
			$display("All tests passed!");
			$finish;
		end else begin
			stop_with_failure("Bound assertions reported errors");
		end
	end

	initial begin
		#(WATCHDOG_CYCLES * 4);
		stop_with_failure("Timeout, the run did not finish in time");
	end

endmodule

// ==== verif/smpc_sva.sv ====
`timescale 1ns/100ps

module smpc_sva (
	input logic CLK,
	input logic RST_N,
	input logic cmd_valid,
	input logic cmd_ready,
	input logic report_valid,
	input logic report_ready,
	input logic MSHRES_N,
	input logic MSHNMI_N,
	input logic SSHRES_N,
	input logic SSHNMI_N,
	input logic SYSRES_N,
	input logic SNDRES_N,
	input logic CDRES_N,
	input logic MIRQ_N
);
	int err_cnt = 0;

	a_cmd_hold: assert property (@(posedge CLK) disable iff (!RST_N)
		cmd_valid && !cmd_ready |=> cmd_valid)
	else begin
		$error("cmd_valid dropped before cmd_ready");
		err_cnt++;
	end

	a_report_hold: assert property (@(posedge CLK) disable iff (!RST_N)
		report_valid && !report_ready |=> report_valid)
	else begin
		$error("report_valid dropped before report_ready");
		err_cnt++;
	end

	// Single clock interrupt request
	a_mirq_pulse: assert property (@(posedge CLK) disable iff (!RST_N)
		!MIRQ_N |=> MIRQ_N)
	else begin
		$error("MIRQ_N low for more than one clock");
		err_cnt++;
	end

	a_sysres_all: assert property (@(posedge CLK) disable iff (!RST_N)
		$fell(SYSRES_N) |-> !MSHRES_N && !MSHNMI_N && !SSHRES_N && !SSHNMI_N
			&& !SNDRES_N && !CDRES_N)
	else begin
		$error("SYSRES did not pull all reset lines low together");
		err_cnt++;
	end

endmodule

// ==== source/smpc_top.sv ====
`timescale 1ns/100ps
`include "smpc_defs.svh"

module smpc_top #(
	parameter int SEC_DIV = `SMPC_SEC_DIV_DEFAULT
) (
	input  logic                     CLK,
	input  logic                     RST_N,
	input  logic                     CE,
	input  smpc_host_pkg::bus_addr_t A,
	input  smpc_host_pkg::byte_t     DI,
	output smpc_host_pkg::byte_t     DO,
	input  logic                     CS_N,
	input  logic                     RW_N,
	input  logic                     SRES_N,
	input  logic [3:0]               AC,
	output logic                     MSHRES_N,
	output logic                     MSHNMI_N,
	output logic                     SSHRES_N,
	output logic                     SSHNMI_N,
	output logic                     SYSRES_N,
	output logic                     SNDRES_N,
	output logic                     CDRES_N,
	output logic                     MIRQ_N
);
	import smpc_host_pkg::*;
	import smpc_ctrl_pkg::*;

	logic       cmd_valid, cmd_ready, cmd_done, intback_done;
	logic       report_valid, report_full, report_ready, report_done;
	logic       resd;
	byte_t      cmd_code, ireg0, ireg2, oreg_rdata;
	oreg_addr_t oreg_raddr;
	bcd_t       sec, min, hour, day;

	smpc_bus_regs u_bus (
		.CLK, .RST_N, .a(A), .di(DI), .cs_n(CS_N), .rw_n(RW_N), .sres_n(SRES_N),
		.do_q(DO), .cmd_valid, .cmd_code, .cmd_ready, .cmd_done, .intback_done,
		.ireg0, .ireg2, .oreg_raddr, .oreg_rdata
	);

	smpc_reset_seq u_seq (
		.CLK, .RST_N, .ce(CE), .cmd_valid, .cmd_code, .cmd_ready, .ireg0, .ireg2,
		.sres_n(SRES_N), .report_valid, .report_full, .report_ready, .report_done,
		.cmd_done, .intback_done, .mshres_n(MSHRES_N), .mshnmi_n(MSHNMI_N),
		.sshres_n(SSHRES_N), .sshnmi_n(SSHNMI_N), .sysres_n(SYSRES_N),
		.sndres_n(SNDRES_N), .cdres_n(CDRES_N), .mirq_n(MIRQ_N), .resd
	);

	smpc_rtc #(.SEC_DIV(SEC_DIV)) u_rtc (.CLK, .RST_N, .ce(CE), .sec, .min, .hour, .day);

	// Report samples time and line state as each byte is stored
	smpc_oreg_report u_rpt (
		.CLK, .RST_N, .ce(CE), .report_valid, .report_full, .report_ready, .report_done,
		.cmd_code, .sec, .min, .hour, .day, .ac(AC), .resd, .mshnmi_n(MSHNMI_N),
		.sysres_n(SYSRES_N), .sndres_n(SNDRES_N), .cdres_n(CDRES_N),
		.raddr(oreg_raddr), .rdata(oreg_rdata)
	);

endmodule

// ==== source/smpc_oreg_report.sv ====
`timescale 1ns/100ps
`include "smpc_defs.svh"

module smpc_oreg_report (
	input  logic                      CLK,
	input  logic                      RST_N,
	input  logic                      ce,
	input  logic                      report_valid,
	input  logic                      report_full,
	output logic                      report_ready,
	output logic                      report_done,
	input  smpc_host_pkg::byte_t      cmd_code,
	input  smpc_ctrl_pkg::bcd_t       sec,
	input  smpc_ctrl_pkg::bcd_t       min,
	input  smpc_ctrl_pkg::bcd_t       hour,
	input  smpc_ctrl_pkg::bcd_t       day,
	input  logic [3:0]                ac,
	input  logic                      resd,
	input  logic                      mshnmi_n,
	input  logic                      sysres_n,
	input  logic                      sndres_n,
	input  logic                      cdres_n,
	input  smpc_host_pkg::oreg_addr_t raddr,
	output smpc_host_pkg::byte_t      rdata
);
	import smpc_host_pkg::*;

	localparam oreg_addr_t LAST = oreg_addr_t'(`SMPC_OREG_LAST);

	byte_t      mem [32];
	byte_t      wdata;
	oreg_addr_t wcnt;
	logic       busy;

	assign report_ready = !busy;
	assign rdata = mem[raddr];

	always_comb begin
		case (wcnt)
			5'd0: wdata = {1'b0, resd, 6'b000000};
			5'd1: wdata = `SMPC_RPT_B1;
			5'd2: wdata = `SMPC_RPT_B2;
			5'd3: wdata = `SMPC_RPT_B3;
			5'd4: wdata = day;
			5'd5: wdata = hour;
			5'd6: wdata = min;
			5'd7: wdata = sec;
			5'd9: wdata = {4'b0000, ac};
			5'd10: wdata = {4'b0011, ~mshnmi_n, 1'b1, ~sysres_n, ~sndres_n};
			5'd11: wdata = {1'b0, ~cdres_n, 6'b000000};
			LAST: wdata = cmd_code;
			default: wdata = '0;
		endcase
	end

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			busy <= 1'b0;
			wcnt <= '0;
			report_done <= 1'b0;
		end else begin
			report_done <= 1'b0;
			if (report_valid && report_ready) begin
				busy <= 1'b1;
				wcnt <= report_full ? '0 : LAST; // Short report is the echo only
			end else if (busy && ce) begin
				wcnt <= wcnt + 1'b1;
				if (wcnt == LAST) begin
					busy <= 1'b0;
					report_done <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (busy && ce) mem[wcnt] <= wdata;
	end

endmodule

// ==== source/smpc_rtc.sv ====
`timescale 1ns/100ps
`include "smpc_defs.svh"

module smpc_rtc #(
	parameter int SEC_DIV = `SMPC_SEC_DIV_DEFAULT
) (
	input  logic                CLK,
	input  logic                RST_N,
	input  logic                ce,
	output smpc_ctrl_pkg::bcd_t sec,
	output smpc_ctrl_pkg::bcd_t min,
	output smpc_ctrl_pkg::bcd_t hour,
	output smpc_ctrl_pkg::bcd_t day
);
	import smpc_ctrl_pkg::*;

	localparam int DIV_W = $clog2(SEC_DIV + 1);

	logic [DIV_W-1:0] div_cnt;
	logic             tick;

	// Wraps to zero after last, otherwise a plain BCD increment
	function automatic bcd_t bcd_inc(input bcd_t v, input bcd_t last);
		if (v == last) return '0;
		if (v[3:0] == 4'd9) return {v[7:4] + 4'd1, 4'd0};
		return {v[7:4], v[3:0] + 4'd1};
	endfunction

	assign tick = ce && (div_cnt == DIV_W'(SEC_DIV - 1));

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			div_cnt <= '0;
			sec <= '0;
			min <= '0;
			hour <= '0;
			day <= '0;
		end else begin
			if (ce) div_cnt <= tick ? '0 : div_cnt + 1'b1;
			if (tick) begin
				sec <= bcd_inc(sec, 8'h59);
				if (sec == 8'h59) min <= bcd_inc(min, 8'h59);
				if (sec == 8'h59 && min == 8'h59) hour <= bcd_inc(hour, 8'h23);
				if (sec == 8'h59 && min == 8'h59 && hour == 8'h23)
					day <= bcd_inc(day, 8'h99);
			end
		end
	end

endmodule

// ==== source/smpc_reset_seq.sv ====
`timescale 1ns/100ps
`include "smpc_defs.svh"

module smpc_reset_seq (
	input  logic                 CLK,
	input  logic                 RST_N,
	input  logic                 ce,
	input  logic                 cmd_valid,
	input  smpc_host_pkg::byte_t cmd_code,
	output logic                 cmd_ready,
	input  smpc_host_pkg::byte_t ireg0,
	input  smpc_host_pkg::byte_t ireg2,
	input  logic                 sres_n,
	output logic                 report_valid,
	output logic                 report_full,
	input  logic                 report_ready,
	input  logic                 report_done,
	output logic                 cmd_done,
	output logic                 intback_done,
	output logic                 mshres_n,
	output logic                 mshnmi_n,
	output logic                 sshres_n,
	output logic                 sshnmi_n,
	output logic                 sysres_n,
	output logic                 sndres_n,
	output logic                 cdres_n,
	output logic                 mirq_n,
	output logic                 resd
);
	import smpc_ctrl_pkg::*;

	seq_state_t state;
	cmd_code_t  cmd_q;
	wait_cnt_t  wait_cnt;
	wait_cnt_t  sres_cnt;
	logic       sres_lock; // Held until the button is released
	logic       full_q;

	assign cmd_ready = (state == SEQ_IDLE) && ce && (sres_cnt == '0);
	assign cmd_done = (state == SEQ_END) && ce;
	assign intback_done = cmd_done && full_q;
	assign mirq_n = !intback_done;
	assign report_full = full_q;

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			state <= SEQ_IDLE;
			cmd_q <= CMD_MSHON;
			wait_cnt <= '0;
			sres_cnt <= '0;
			sres_lock <= 1'b0;
			full_q <= 1'b0;
			report_valid <= 1'b0;
			{mshres_n, mshnmi_n, sshres_n, sshnmi_n} <= 4'b1101;
			{sysres_n, sndres_n, cdres_n} <= 3'b101;
			resd <= 1'b1;
		end else begin
			if (report_valid && report_ready) report_valid <= 1'b0;

			if (ce) begin
				case (state)
					SEQ_IDLE: if (cmd_valid && cmd_ready) begin
						cmd_q <= cmd_code_t'(cmd_code);
						full_q <= 1'b0;
						state <= SEQ_START;
					end
					SEQ_START: begin
						state <= SEQ_WAIT;
						case (cmd_q)
							CMD_MSHON, CMD_SSHON, CMD_SSHOFF, CMD_SNDON, CMD_SNDOFF:
								wait_cnt <= wait_cnt_t'(`SMPC_WAIT_PWR);
							CMD_CDON, CMD_CDOFF: wait_cnt <= wait_cnt_t'(`SMPC_WAIT_CD);
							CMD_SYSRES: wait_cnt <= wait_cnt_t'(`SMPC_WAIT_SYSRES);
							CMD_NMIREQ, CMD_RESENAB, CMD_RESDISA:
								wait_cnt <= wait_cnt_t'(`SMPC_WAIT_NMI);
							CMD_INTBACK: if (ireg2 == 8'hF0 && ireg0[0]) begin
								full_q <= 1'b1;
								wait_cnt <= wait_cnt_t'(`SMPC_WAIT_INTBACK);
							end else begin
								state <= SEQ_END; // Nothing to report
							end
							default: state <= SEQ_EXEC;
						endcase
					end
					SEQ_WAIT: begin
						wait_cnt <= wait_cnt - 1'b1;
						if (wait_cnt == wait_cnt_t'(1)) state <= SEQ_EXEC;
					end
					SEQ_EXEC: begin
						case (cmd_q)
							CMD_MSHON: {mshres_n, mshnmi_n} <= 2'b11;
							CMD_SSHON: {sshres_n, sshnmi_n} <= 2'b11;
							CMD_SSHOFF: {sshres_n, sshnmi_n} <= 2'b01;
							CMD_SNDON: sndres_n <= 1'b1;
							CMD_SNDOFF: sndres_n <= 1'b0;
							CMD_CDON: cdres_n <= 1'b1;
							CMD_CDOFF: cdres_n <= 1'b0;
							CMD_SYSRES: begin
								{mshres_n, mshnmi_n, sshres_n, sshnmi_n} <= 4'b0000;
								{sysres_n, sndres_n, cdres_n} <= 3'b000;
							end
							CMD_NMIREQ: mshnmi_n <= 1'b0;
							CMD_RESENAB: resd <= 1'b0;
							CMD_RESDISA: resd <= 1'b1;
							default: ;
						endcase
						report_valid <= 1'b1;
						state <= SEQ_REPORT;
					end
					SEQ_END: begin
						if (cmd_q == CMD_SYSRES) begin
							{mshres_n, mshnmi_n, sshres_n, sshnmi_n} <= 4'b1111;
							{sysres_n, sndres_n, cdres_n} <= 3'b111;
						end
						if (cmd_q == CMD_NMIREQ) mshnmi_n <= 1'b1;
						state <= SEQ_IDLE;
					end
					default: ; // REPORT leaves on report_done
				endcase

				// Reset button NMI
				if (sres_cnt != '0) begin
					sres_cnt <= sres_cnt - 1'b1;
					if (sres_cnt == wait_cnt_t'(1)) {mshnmi_n, sshnmi_n} <= 2'b11;
				end else if (sres_lock) begin
					if (sres_n) sres_lock <= 1'b0;
				end else if (!sres_n && !resd) begin
					sres_cnt <= wait_cnt_t'(`SMPC_WAIT_SRES);
					sres_lock <= 1'b1;
					{mshnmi_n, sshnmi_n} <= 2'b00;
				end
			end

			if (state == SEQ_REPORT && report_done) state <= SEQ_END;
		end
	end

endmodule

// ==== source/smpc_bus_regs.sv ====
`timescale 1ns/100ps
`include "smpc_defs.svh"

module smpc_bus_regs (
	input  logic                     CLK,
	input  logic                     RST_N,
	input  smpc_host_pkg::bus_addr_t a,
	input  smpc_host_pkg::byte_t     di,
	input  logic                     cs_n,
	input  logic                     rw_n,
	input  logic                     sres_n,
	output smpc_host_pkg::byte_t     do_q,
	output logic                     cmd_valid,
	output smpc_host_pkg::byte_t     cmd_code,
	input  logic                     cmd_ready,
	input  logic                     cmd_done,
	input  logic                     intback_done,
	output smpc_host_pkg::byte_t     ireg0,
	output smpc_host_pkg::byte_t     ireg2,
	output smpc_host_pkg::oreg_addr_t oreg_raddr,
	input  smpc_host_pkg::byte_t     oreg_rdata
);
	import smpc_host_pkg::*;

	logic       rw_n_q;
	logic       cs_n_q;
	logic [6:0] addr;
	logic       wr_stb;
	logic       rd_stb;
	logic       sf;
	logic [2:0] sr_hi;
	byte_t      ireg1;
	byte_t      sr;
	bus_addr_t  oreg_off;

	assign addr = {a, 1'b1};
	assign wr_stb = !rw_n && rw_n_q && !cs_n;
	assign rd_stb = !cs_n && cs_n_q && rw_n;
	assign sr = {sr_hi, ~sres_n, ireg1[7:4]};
	assign oreg_off = a - 6'h10; // OREG0 sits at 21h
	assign oreg_raddr = oreg_off[4:0];

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			rw_n_q <= 1'b1;
			cs_n_q <= 1'b1;
			ireg0 <= '0;
			ireg1 <= '0;
			ireg2 <= '0;
			cmd_code <= '0;
			cmd_valid <= 1'b0;
			sf <= 1'b0;
			sr_hi <= '0;
			do_q <= '0;
		end else begin
			rw_n_q <= rw_n;
			cs_n_q <= cs_n;
			if (cmd_valid && cmd_ready) cmd_valid <= 1'b0;
			if (cmd_done) sf <= 1'b0;
			if (intback_done) sr_hi <= 3'b010;

			if (wr_stb) begin
				case (addr)
					7'h01: ireg0 <= di;
					7'h03: ireg1 <= di;
					7'h05: ireg2 <= di;
					`SMPC_ADDR_COMREG: begin
						cmd_code <= di; // Latest write wins until accepted
						cmd_valid <= 1'b1;
						sf <= 1'b1;
						sr_hi <= '0;
					end
					`SMPC_ADDR_SF: if (di[0]) sf <= 1'b1;
					default: ;
				endcase
			end

			if (rd_stb) begin
				if (addr >= 7'h21 && addr <= 7'h5F) do_q <= oreg_rdata;
				else if (addr == `SMPC_ADDR_SR) do_q <= sr;
				else if (addr == `SMPC_ADDR_SF) do_q <= {7'b0000000, sf};
				else do_q <= '0;
			end
		end
	end

endmodule

// ==== source/smpc_ctrl_pkg.sv ====
package smpc_ctrl_pkg;

	// Codes outside this list run as no-op commands
	typedef enum logic [7:0] {
		CMD_MSHON   = 8'h00,
		CMD_SSHON   = 8'h02,
		CMD_SSHOFF  = 8'h03,
		CMD_SNDON   = 8'h06,
		CMD_SNDOFF  = 8'h07,
		CMD_CDON    = 8'h08,
		CMD_CDOFF   = 8'h09,
		CMD_SYSRES  = 8'h0D,
		CMD_INTBACK = 8'h10,
		CMD_NMIREQ  = 8'h18,
		CMD_RESENAB = 8'h19,
		CMD_RESDISA = 8'h1A
	} cmd_code_t;

	typedef enum logic [5:0] {
		SEQ_IDLE   = 6'b000001,
		SEQ_START  = 6'b000010,
		SEQ_WAIT   = 6'b000100,
		SEQ_EXEC   = 6'b001000,
		SEQ_REPORT = 6'b010000,
		SEQ_END    = 6'b100000
	} seq_state_t;

	typedef logic [15:0] wait_cnt_t;
	typedef logic [7:0] bcd_t; // Two BCD digits

endpackage

// ==== source/smpc_host_pkg.sv ====
package smpc_host_pkg;

	// Host data bus byte
	typedef logic [7:0] byte_t;

	// Word address pins A[6:1]
	typedef logic [5:0] bus_addr_t;

	// Index into the 32 byte output register area
	typedef logic [4:0] oreg_addr_t;

endpackage

// ==== source/smpc_defs.svh ====
`ifndef SMPC_DEFS_SVH
`define SMPC_DEFS_SVH

// Command waits in CE cycles
`define SMPC_WAIT_PWR        120
`define SMPC_WAIT_CD         159
`define SMPC_WAIT_SYSRES     400
`define SMPC_WAIT_INTBACK    500
`define SMPC_WAIT_NMI        127
`define SMPC_WAIT_SRES       60000 // Reset button NMI length

`define SMPC_SEC_DIV_DEFAULT 4000000

// Fixed INTBACK status bytes
`define SMPC_RPT_B1          8'h20
`define SMPC_RPT_B2          8'h22
`define SMPC_RPT_B3          8'h01
`define SMPC_OREG_LAST       31 // Command echo slot

`define SMPC_ADDR_COMREG     7'h1F
`define SMPC_ADDR_SR         7'h61
`define SMPC_ADDR_SF         7'h63

`endif
